/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = oramCryptTb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
source/oramCryptPkg.sv
source/keyRequestIf.sv
source/chunkFifo.sv
source/bucketSequencer.sv
source/keystreamLane.sv
source/chunkCombiner.sv
source/oramCryptTop.sv
testbench/oramCryptTb.sv

/* source/bucketSequencer.sv */
/*
 * Bucket sequencer
 * Takes chunks from the active input, tracks the bucket position, issues keystream requests
 */
`timescale 1ns/1ns

module bucketSequencer import oramCryptPkg::*; (
    input  logic      Clock,
    input  logic      rstN,
    input  logic      pathRead,
    input  chunkWordT dramReadData,
    input  chunkWordT backendWriteData,
    input  logic      dramReadValid,
    input  logic      backendWriteValid,
    output logic      dramReadReady,
    output logic      backendWriteReady,
    input  logic      dataFull,
    output logic      dataPush,
    output chunkWordT dataChunk,
    keyRequestIf.source keyReq
);

    chunkWordT                  inChunk;
    logic                       inValid;
    logic                       accept;
    logic                       isHeader;
    logic [ChunkIndexWidth-1:0] chunkIndex;
    logic [IvWidth-1:0]         ivHold;

    // ----------------------------------------------------------------------
    // Input select
    // ----------------------------------------------------------------------
    assign inChunk = pathRead ? dramReadData : backendWriteData;
    assign inValid = pathRead ? dramReadValid : backendWriteValid;

    assign dramReadReady = pathRead && !dataFull;
    assign backendWriteReady = !pathRead && !dataFull;

    assign accept = inValid && !dataFull;

    // ----------------------------------------------------------------------
    // Bucket position and IV
    // ----------------------------------------------------------------------
    assign isHeader = (chunkIndex == '0);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            chunkIndex <= '0;
        end else if (accept) begin
            if (int'(chunkIndex) == BucketChunks - 1) begin
                chunkIndex <= '0;
            end else begin
                chunkIndex <= chunkIndex + 1'b1;
            end
        end
    end

    // IV held for the body chunks of the bucket
    always_ff @(posedge Clock) begin
        if (accept && isHeader) begin
            ivHold <= inChunk.header.iv;
        end
    end

    // Header uses its own IV straight away
    assign keyReq.iv = isHeader ? inChunk.header.iv : ivHold;
    assign keyReq.chunkIndex = chunkIndex;
    assign keyReq.isHeader = isHeader;
    assign keyReq.valid = accept;

    assign dataPush = accept;
    assign dataChunk = inChunk;

    // Offered chunk holds until taken
    assert property (@(posedge Clock) disable iff (!rstN)
        dramReadValid && !dramReadReady |=> dramReadValid && $stable(dramReadData));
    assert property (@(posedge Clock) disable iff (!rstN)
        backendWriteValid && !backendWriteReady |=> backendWriteValid && $stable(backendWriteData));

endmodule

/* source/chunkCombiner.sv */
/*
 * Chunk combiner
 * XORs data with keystream, restores the header IV, steers output and tracks direction
 */
`timescale 1ns/1ns

module chunkCombiner import oramCryptPkg::*; (
    input  logic      Clock,
    input  logic      rstN,
    input  logic      dataEmpty,
    input  logic      keyEmpty,
    input  chunkWordT dataHead,
    input  chunkWordT keyHead,
    input  logic      headIsHeader,
    output logic      pop,
    output logic      pathRead,
    input  logic      dramWriteReady,
    input  logic      backendReadReady,
    output chunkWordT outChunk,
    output logic      dramWriteValid,
    output logic      backendReadValid
);

    chunkWordT                 xorWord;
    logic                      headValid;
    logic                      outReady;
    logic                      pathDone;
    logic [PathCountWidth-1:0] pathCount;

    // ----------------------------------------------------------------------
    // Output word
    // ----------------------------------------------------------------------
    assign xorWord = dataHead ^ keyHead;

    always_comb begin
        outChunk = xorWord;
        // IV field passes through in the clear
        if (headIsHeader) begin
            outChunk.header.iv = dataHead.header.iv;
        end
    end

    // ----------------------------------------------------------------------
    // Handshake and direction
    // ----------------------------------------------------------------------
    assign headValid = !dataEmpty && !keyEmpty;
    assign outReady = pathRead ? backendReadReady : dramWriteReady;

    assign backendReadValid = pathRead && headValid;
    assign dramWriteValid = !pathRead && headValid;

    assign pop = headValid && outReady;
    assign pathDone = pop && (int'(pathCount) == PathChunks - 1);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pathCount <= '0;
            pathRead <= 1'b1;
        end else if (pop) begin
            if (pathDone) begin
                pathCount <= '0;
                pathRead <= !pathRead;
            end else begin
                pathCount <= pathCount + 1'b1;
            end
        end
    end

    // Keystream never runs ahead of its data chunk
    assert property (@(posedge Clock) disable iff (!rstN) !keyEmpty |-> !dataEmpty);

endmodule

/* source/chunkFifo.sv */
/*
 * Chunk FIFO
 * Synchronous first-word-fall-through buffer of FifoDepth entries
 */
`timescale 1ns/1ns

module chunkFifo import oramCryptPkg::*; #(
    parameter int Width = ChunkWidth
) (
    input  logic             Clock,
    input  logic             rstN,
    input  logic             push,
    input  logic [Width-1:0] pushData,
    output logic             full,
    input  logic             pop,
    output logic [Width-1:0] popData,
    output logic             empty
);

    logic [Width-1:0]               mem [FifoDepth];
    logic [$clog2(FifoDepth)-1:0]   wrPtr;
    logic [$clog2(FifoDepth)-1:0]   rdPtr;
    logic [$clog2(FifoDepth+1)-1:0] count;

    assign full = (int'(count) == FifoDepth);
    assign empty = (count == '0);

    // Head is valid whenever not empty
    assign popData = mem[rdPtr];

    always_ff @(posedge Clock) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (int'(wrPtr) == FifoDepth - 1) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (int'(rdPtr) == FifoDepth - 1) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Callers must honour full and empty
    assert property (@(posedge Clock) disable iff (!rstN) push |-> !full);
    assert property (@(posedge Clock) disable iff (!rstN) pop |-> !empty);

endmodule

/* source/keyRequestIf.sv */
/*
 * Keystream request bus from the bucket sequencer to the lanes
 */
`timescale 1ns/1ns

interface keyRequestIf import oramCryptPkg::*; ();

    logic [IvWidth-1:0]         iv;
    logic [ChunkIndexWidth-1:0] chunkIndex;
    logic                       isHeader;
    // No ready, lanes always accept
    logic                       valid;

    modport source (
        output iv, chunkIndex, isHeader, valid
    );

    modport sink (
        input iv, chunkIndex, isHeader, valid
    );

endinterface

/* source/keystreamLane.sv */
/*
 * Keystream lane
 * Four stage add-rotate-xor pipeline producing one 32-bit keystream word
 */
`timescale 1ns/1ns

module keystreamLane import oramCryptPkg::*; #(
    parameter int LaneIndex = 0
) (
    input  logic                 Clock,
    input  logic                 rstN,
    keyRequestIf.sink            keyReq,
    output logic [LaneWidth-1:0] laneWord,
    output logic                 laneValid
);

    logic [LaneWidth-1:0] seedA;
    logic [LaneWidth-1:0] seedB;
    logic [LaneWidth-1:0] stageA [MixRounds];
    logic [LaneWidth-1:0] stageB [MixRounds];
    logic [MixRounds-1:0] stageValid;

    // One round, returns {a, b}
    function automatic logic [2*LaneWidth-1:0] mixRound(
        input logic [LaneWidth-1:0] a,
        input logic [LaneWidth-1:0] b
    );
        logic [LaneWidth-1:0] nextA;
        logic [LaneWidth-1:0] nextB;
        nextA = a + b;
        nextB = {b[LaneWidth-RotateAmount-1:0], b[LaneWidth-1:LaneWidth-RotateAmount]} ^ nextA;
        return {nextA, nextB};
    endfunction

    // Counter word is chunk index times lane count plus this lane
    assign seedA = keyReq.iv[LaneWidth-1:0] ^ KeyWord;
    assign seedB = keyReq.iv[2*LaneWidth-1:LaneWidth]
                 + LaneWidth'(keyReq.chunkIndex) * LaneWidth'(LaneCount)
                 + LaneWidth'(LaneIndex);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[MixRounds-2:0], keyReq.valid};
        end
    end

    always_ff @(posedge Clock) begin
        {stageA[0], stageB[0]} <= mixRound(seedA, seedB);
        for (int i = 1; i < MixRounds; i++) begin
            {stageA[i], stageB[i]} <= mixRound(stageA[i-1], stageB[i-1]);
        end
    end

    assign laneWord = stageA[MixRounds-1] ^ stageB[MixRounds-1];
    assign laneValid = stageValid[MixRounds-1];

endmodule

/* source/oramCryptPkg.sv */
/*
 * ORAM bucket crypt package
 * Sizes, fixed key, keystream round constants and the chunk word type
 */
package oramCryptPkg;

    // ----------------------------------------------------------------------
    // Chunk and lane geometry
    // ----------------------------------------------------------------------
    localparam int LaneWidth = 32;
    localparam int LaneCount = 4;
    localparam int ChunkWidth = LaneWidth * LaneCount;

    // IV sits in the low bits of the header chunk
    localparam int IvWidth = 64;

    // ----------------------------------------------------------------------
    // Bucket and path geometry
    // ----------------------------------------------------------------------
    localparam int BucketChunks = 8;
    localparam int PathBuckets = 4;
    localparam int PathChunks = PathBuckets * BucketChunks;
    localparam int ChunkIndexWidth = 3;
    localparam int PathCountWidth = 5;

    localparam int FifoDepth = 8;

    // ----------------------------------------------------------------------
    // Keystream function
    // ----------------------------------------------------------------------
    localparam logic [LaneWidth-1:0] KeyWord = '1;
    // One round per pipeline stage
    localparam int MixRounds = 4;
    localparam int RotateAmount = 7;

    // Header view of a chunk, body bits above the IV
    typedef struct packed {
        logic [ChunkWidth-IvWidth-1:0] body;
        logic [IvWidth-1:0]            iv;
    } chunkHeaderT;

    // Same 128 bits seen as keystream lanes or as a bucket header
    typedef union packed {
        logic [LaneCount-1:0][LaneWidth-1:0] lanes;
        chunkHeaderT                         header;
    } chunkWordT;

endpackage

/* source/oramCryptTop.sv */
/*
 * ORAM bucket encryption stage
 * Decrypts DRAM paths toward the backend and encrypts backend paths toward DRAM
 */
`timescale 1ns/1ns

module oramCryptTop import oramCryptPkg::*; (
    input  logic                  Clock,
    input  logic                  rstN,
    input  logic [ChunkWidth-1:0] dramReadData,
    input  logic                  dramReadValid,
    output logic                  dramReadReady,
    output logic [ChunkWidth-1:0] dramWriteData,
    output logic                  dramWriteValid,
    input  logic                  dramWriteReady,
    input  logic [ChunkWidth-1:0] backendWriteData,
    input  logic                  backendWriteValid,
    output logic                  backendWriteReady,
    output logic [ChunkWidth-1:0] backendReadData,
    output logic                  backendReadValid,
    input  logic                  backendReadReady
);

    keyRequestIf keyReq ();

    logic                                pathRead;
    logic                                dataFull;
    logic                                dataPush;
    chunkWordT                           dataChunk;
    logic [ChunkWidth:0]                 dataFifoOut;
    logic                                dataEmpty;
    logic [LaneCount-1:0][LaneWidth-1:0] laneWords;
    logic [LaneCount-1:0]                laneValid;
    chunkWordT                           keyHead;
    logic                                keyEmpty;
    logic                                pop;
    chunkWordT                           outChunk;

    bucketSequencer i_sequencer (
        .Clock(Clock),
        .rstN(rstN),
        .pathRead(pathRead),
        .dramReadData(dramReadData),
        .backendWriteData(backendWriteData),
        .dramReadValid(dramReadValid),
        .backendWriteValid(backendWriteValid),
        .dramReadReady(dramReadReady),
        .backendWriteReady(backendWriteReady),
        .dataFull(dataFull),
        .dataPush(dataPush),
        .dataChunk(dataChunk),
        .keyReq(keyReq)
    );

    for (genvar lane = 0; lane < LaneCount; lane++) begin : genLane
        keystreamLane #(.LaneIndex(lane)) i_lane (
            .Clock(Clock),
            .rstN(rstN),
            .keyReq(keyReq),
            .laneWord(laneWords[lane]),
            .laneValid(laneValid[lane])
        );
    end

    // Chunk plus header flag
    chunkFifo #(.Width(ChunkWidth + 1)) i_dataFifo (
        .Clock(Clock),
        .rstN(rstN),
        .push(dataPush),
        .pushData({keyReq.isHeader, dataChunk}),
        .full(dataFull),
        .pop(pop),
        .popData(dataFifoOut),
        .empty(dataEmpty)
    );

    // Never fuller than the data FIFO
    chunkFifo #(.Width(ChunkWidth)) i_keyFifo (
        .Clock(Clock),
        .rstN(rstN),
        .push(&laneValid),
        .pushData(laneWords),
        .full(),
        .pop(pop),
        .popData(keyHead),
        .empty(keyEmpty)
    );

    chunkCombiner i_combiner (
        .Clock(Clock),
        .rstN(rstN),
        .dataEmpty(dataEmpty),
        .keyEmpty(keyEmpty),
        .dataHead(dataFifoOut[ChunkWidth-1:0]),
        .keyHead(keyHead),
        .headIsHeader(dataFifoOut[ChunkWidth]),
        .pop(pop),
        .pathRead(pathRead),
        .dramWriteReady(dramWriteReady),
        .backendReadReady(backendReadReady),
        .outChunk(outChunk),
        .dramWriteValid(dramWriteValid),
        .backendReadValid(backendReadValid)
    );

    assign dramWriteData = outChunk;
    assign backendReadData = outChunk;

endmodule

/* testbench/oramCryptTb.sv */
/*
 * Testbench for the ORAM bucket encryption stage
 * Checks paths in both directions against a reference keystream model
 */
`timescale 1ns/1ns

module oramCryptTb import oramCryptPkg::*; ();

    localparam int NumPaths = 7;
    localparam logic [31:0] Seed = 32'h4477880b;

    logic                  Clock;
    logic                  rstN;
    logic [ChunkWidth-1:0] dramReadData;
    logic                  dramReadValid;
    logic                  dramReadReady;
    logic [ChunkWidth-1:0] dramWriteData;
    logic                  dramWriteValid;
    logic                  dramWriteReady;
    logic [ChunkWidth-1:0] backendWriteData;
    logic                  backendWriteValid;
    logic                  backendWriteReady;
    logic [ChunkWidth-1:0] backendReadData;
    logic                  backendReadValid;
    logic                  backendReadReady;

    chunkWordT expQ [$];
    logic      expToBackend [$];
    chunkWordT pathIn [PathChunks];
    chunkWordT pathOut [PathChunks];
    chunkWordT plainSaved [PathChunks];
    int        outCount;
    logic      stallOutputs;

    oramCryptTop i_dut (
        .Clock(Clock),
        .rstN(rstN),
        .dramReadData(dramReadData),
        .dramReadValid(dramReadValid),
        .dramReadReady(dramReadReady),
        .dramWriteData(dramWriteData),
        .dramWriteValid(dramWriteValid),
        .dramWriteReady(dramWriteReady),
        .backendWriteData(backendWriteData),
        .backendWriteValid(backendWriteValid),
        .backendWriteReady(backendWriteReady),
        .backendReadData(backendReadData),
        .backendReadValid(backendReadValid),
        .backendReadReady(backendReadReady)
    );

    always #50 Clock = ~Clock;

    task automatic stopRun(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic checkChunk(input chunkWordT got, input chunkWordT exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("FAILED at %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    // ----------------------------------------------------------------------
    // Reference model of keystream and output rules
    // ----------------------------------------------------------------------
    function automatic chunkWordT expectedChunk(input chunkWordT inChunk,
                                                input logic [IvWidth-1:0] iv, input int index);
        chunkWordT            ks;
        chunkWordT            result;
        logic [LaneWidth-1:0] a;
        logic [LaneWidth-1:0] b;
        for (int j = 0; j < LaneCount; j++) begin
            a = iv[31:0] ^ KeyWord;
            b = iv[63:32] + 32'(index * LaneCount + j);
            for (int r = 0; r < MixRounds; r++) begin
                a = a + b;
                b = ((b << RotateAmount) | (b >> (LaneWidth - RotateAmount))) ^ a;
            end
            ks.lanes[j] = a ^ b;
        end
        result.lanes = inChunk.lanes ^ ks.lanes;
        // Header IV stays in the clear
        if (index == 0) begin
            result.header.iv = inChunk.header.iv;
        end
        return result;
    endfunction

    function automatic chunkWordT randomChunk();
        chunkWordT c;
        for (int j = 0; j < LaneCount; j++) begin
            c.lanes[j] = $urandom;
        end
        return c;
    endfunction

    // Sends pathIn on one input, queues expected outputs, waits for drain
    task automatic sendPath(input logic onDram);
        logic [IvWidth-1:0] iv;
        int                 index;
        logic               accepted;
        outCount = 0;
        iv = '0;
        for (int i = 0; i < PathChunks; i++) begin
            index = i % BucketChunks;
            if (index == 0) begin
                iv = pathIn[i].header.iv;
            end
            expQ.push_back(expectedChunk(pathIn[i], iv, index));
            expToBackend.push_back(onDram);
            if (onDram) begin
                dramReadData = pathIn[i];
                dramReadValid = 1'b1;
            end else begin
                backendWriteData = pathIn[i];
                backendWriteValid = 1'b1;
            end
            do begin
                @(negedge Clock);
                accepted = onDram ? dramReadReady : backendWriteReady;
                if (accepted) begin
                    checkBit(onDram ? backendWriteReady : dramReadReady, 1'b0,
                             "ready on the idle input");
                end
                @(posedge Clock);
                #10;
            end while (!accepted);
        end
        dramReadValid = 1'b0;
        backendWriteValid = 1'b0;
        while (expQ.size() != 0) begin
            @(posedge Clock);
            #10;
        end
    endtask

    task automatic takeOutput(input chunkWordT got);
        checkChunk(got, expQ.pop_front(), "output chunk");
        void'(expToBackend.pop_front());
        pathOut[outCount] = got;
        outCount++;
    endtask

    // ----------------------------------------------------------------------
    // Output compare, sampled mid cycle
    // ----------------------------------------------------------------------
    always @(negedge Clock) begin
        if (rstN && (backendReadValid || dramWriteValid)) begin
            if (expQ.size() == 0) begin
                stopRun("The DUT raised an output valid with no chunk outstanding");
            end else begin
                checkBit(backendReadValid, expToBackend[0], "backendRead valid");
                checkBit(dramWriteValid, !expToBackend[0], "dramWrite valid");
                if (backendReadValid && backendReadReady) begin
                    takeOutput(backendReadData);
                end else if (dramWriteValid && dramWriteReady) begin
                    takeOutput(dramWriteData);
                end
            end
        end
    end

    // Output readys, random low pulses when stalling
    always @(posedge Clock) begin
        #10;
        if (stallOutputs) begin
            dramWriteReady = ($urandom_range(3) != 0);
            backendReadReady = ($urandom_range(3) != 0);
        end else begin
            dramWriteReady = 1'b1;
            backendReadReady = 1'b1;
        end
    end

    initial begin
        repeat (NumPaths * PathChunks * 20 + 200) @(posedge Clock);
        stopRun("Timeout because the DUT did not finish all paths in time");
    end

    initial begin
        void'($urandom(Seed));
        Clock = 1'b0;
        rstN = 1'b0;
        dramReadData = '0;
        dramReadValid = 1'b0;
        dramWriteReady = 1'b1;
        backendWriteData = '0;
        backendWriteValid = 1'b0;
        backendReadReady = 1'b1;
        stallOutputs = 1'b0;
        outCount = 0;
        repeat (2) @(posedge Clock);
        #10;
        rstN = 1'b1;

        @(negedge Clock);
        checkBit(dramWriteValid, 1'b0, "dramWriteValid after reset");
        checkBit(backendReadValid, 1'b0, "backendReadValid after reset");
        checkBit(backendWriteReady, 1'b0, "backendWriteReady after reset");
        @(posedge Clock);
        #10;

        // Path read, then a write path
        for (int i = 0; i < PathChunks; i++) begin
            pathIn[i] = randomChunk();
        end
        sendPath(1'b1);
        for (int i = 0; i < PathChunks; i++) begin
            pathIn[i] = randomChunk();
            plainSaved[i] = pathIn[i];
        end
        sendPath(1'b0);

        // Ciphertext fed back as a read path
        for (int i = 0; i < PathChunks; i++) begin
            pathIn[i] = pathOut[i];
        end
        sendPath(1'b1);
        for (int i = 0; i < PathChunks; i++) begin
            checkChunk(pathOut[i], plainSaved[i], "round trip chunk");
        end

        stallOutputs = 1'b1;
        for (int p = 3; p < NumPaths; p++) begin
            for (int i = 0; i < PathChunks; i++) begin
                pathIn[i] = randomChunk();
            end
            sendPath(p % 2 == 0);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule
